/* aes_128_pipe.f */
aes_pkg.sv
aes_sbox.sv
aes_key_stage.sv
aes_round.sv
aes_128_pipe.sv
tb_aes_128_pipe.sv

/* tb_aes_128_pipe.sv */
`timescale 1ns/1ps

module tb_aes_128_pipe;

  localparam int reset_cycles = 16;
  localparam int num_vectors = 4;
  // passes 0 to 2 run back to back and later passes get random bubbles
  localparam int stream_passes = 3;
  localparam int num_passes = 5;
  localparam int max_gap = 3;
  localparam int drain_idle = 4;

  typedef struct packed {
    logic [127:0] cipher_key;
    logic [127:0] plain;
    logic [127:0] cipher;
    logic [7:0]   gap;
  } vector_t;

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  aes_pkg::block_t plaintext;
  aes_pkg::block_t key;
  logic            out_valid;
  aes_pkg::block_t ciphertext;

  vector_t vectors [0:num_vectors-1];

  // applied sequence with one table index and gap per block
  int run_idx [$];
  int run_gap [$];

  // expected ciphertext and the cycle it was accepted
  logic [127:0] exp_q [$];
  int           cyc_q [$];

  logic [127:0] drv_ct;
  integer       seed;
  int           cycle_count;
  int           timeout_limit;
  int           value_errors;
  int           proto_errors;

  aes_128_pipe u_aes_128_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .plaintext  (plaintext),
    .key        (key),
    .out_valid  (out_valid),
    .ciphertext (ciphertext)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic load_vectors();
    // FIPS-197 appendix C.1
    // its gap leaves idle cycles right after reset
    vectors[0].cipher_key = 128'h000102030405060708090a0b0c0d0e0f;
    vectors[0].plain      = 128'h00112233445566778899aabbccddeeff;
    vectors[0].cipher     = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    vectors[0].gap        = 8'd6;
    // FIPS-197 appendix B
    vectors[1].cipher_key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    vectors[1].plain      = 128'h3243f6a8885a308d313198a2e0370734;
    vectors[1].cipher     = 128'h3925841d02dc09fbdc118597196a0b32;
    vectors[1].gap        = 8'd0;
    // all-zero key and plaintext hit the sbox at input 0
    vectors[2].cipher_key = 128'h0;
    vectors[2].plain      = 128'h0;
    vectors[2].cipher     = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    vectors[2].gap        = 8'd0;
    // SP 800-38A ECB block 1
    vectors[3].cipher_key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    vectors[3].plain      = 128'h6bc1bee22e409f96e93d7e117393172a;
    vectors[3].cipher     = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
    vectors[3].gap        = 8'd0;
  endtask

  // builds the block sequence and the cycle limit for the run
  task automatic build_run();
    int g;
    int gap_sum;
    gap_sum = 0;
    for (int p = 0; p < num_passes; p++)
    begin
      for (int i = 0; i < num_vectors; i++)
      begin
        if (p == 0)
        begin
          g = int'(vectors[i].gap);
        end
        else if (p < stream_passes)
        begin
          g = 0;
        end
        else
        begin
          g = $unsigned($random(seed)) % (max_gap + 1);
        end
        run_idx.push_back(i);
        run_gap.push_back(g);
        gap_sum = gap_sum + g;
      end
    end
    timeout_limit = reset_cycles + run_idx.size() + gap_sum + aes_pkg::pipe_latency + 20;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_entry(input int idx, input int gap);
    repeat (gap)
    begin
      in_valid = 1'b0;
      next_cycle();
    end
    in_valid  = 1'b1;
    key       = vectors[idx].cipher_key;
    plaintext = vectors[idx].plain;
    drv_ct    = vectors[idx].cipher;
    next_cycle();
  endtask

  // pops the oldest block in flight and compares it with the output
  task automatic check_output();
    logic [127:0] exp_ct;
    int           in_cycle;
    assert (exp_q.size() != 0)
    else
    begin
      $display("out_valid was high at cycle %0d with no block in flight", cycle_count);
      proto_errors++;
    end
    if (exp_q.size() != 0)
    begin
      exp_ct = exp_q.pop_front();
      in_cycle = cyc_q.pop_front();
      assert (ciphertext === exp_ct)
      else
      begin
        $display("Error: ciphertext got %h expected %h", ciphertext, exp_ct);
        value_errors++;
      end
      assert (cycle_count - in_cycle == aes_pkg::pipe_latency)
      else
      begin
        $display("Error: latency got %0h expected %0h",
                 cycle_count - in_cycle, aes_pkg::pipe_latency);
        value_errors++;
      end
    end
  endtask

  // scoreboard samples on the rising edge before the DUT registers move
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (!rst_n)
    begin
      // the first reset edge clears every valid register
      if (cycle_count > 1)
      begin
        assert (out_valid === 1'b0)
        else
        begin
          $display("out_valid was not low during reset at cycle %0d", cycle_count);
          proto_errors++;
        end
      end
    end
    else
    begin
      if (in_valid)
      begin
        exp_q.push_back(drv_ct);
        cyc_q.push_back(cycle_count);
      end
      assert (!$isunknown(out_valid))
      else
      begin
        $display("out_valid was unknown at cycle %0d", cycle_count);
        proto_errors++;
      end
      if (out_valid === 1'b1)
      begin
        check_output();
      end
    end
  end

  initial
  begin : watchdog
    int waited;
    waited = 0;
    #1;
    while (waited < timeout_limit)
    begin
      @(posedge clk);
      waited++;
    end
    $display("run did not finish within %0d cycles, %0d blocks still in flight",
             timeout_limit, exp_q.size());
    $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    plaintext    = '0;
    key          = '0;
    drv_ct       = '0;
    value_errors = 0;
    proto_errors = 0;
    seed         = 15098;
    load_vectors();
    build_run();

    repeat (reset_cycles)
    begin
      @(posedge clk);
    end
    #1;
    rst_n = 1'b1;

    for (int n = 0; n < run_idx.size(); n++)
    begin
      apply_entry(run_idx[n], run_gap[n]);
    end
    in_valid = 1'b0;

    // wait out the pipe latency and a few more cycles for stray outputs
    repeat (aes_pkg::pipe_latency + drain_idle)
    begin
      next_cycle();
    end

    assert (exp_q.size() == 0)
    else
    begin
      $display("%0d blocks never came out of the pipe", exp_q.size());
      proto_errors++;
    end

    $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* aes_128_pipe.sv */
`timescale 1ns/1ps

module aes_128_pipe (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  aes_pkg::block_t plaintext,
  input  aes_pkg::block_t key,
  output logic            out_valid,
  output aes_pkg::block_t ciphertext
);

  localparam int cnt_w = $clog2(aes_pkg::pipe_latency + 1);

  // stage 0 registers
  logic            s0_valid;
  aes_pkg::block_t s0_state;
  aes_pkg::block_t s0_key;

  // element i is the output of stage i
  logic            stage_valid [0:aes_pkg::num_rounds];
  aes_pkg::block_t stage_state [0:aes_pkg::num_rounds];
  aes_pkg::block_t stage_key   [0:aes_pkg::num_rounds];
  aes_pkg::block_t round_key   [1:aes_pkg::num_rounds];

  // saturating count of cycles since reset for the latency check
  logic [cnt_w-1:0] since_reset;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      s0_valid <= 1'b0;
    end
    else
    begin
      s0_valid <= in_valid;
    end
  end

  // initial AddRoundKey and the key copy that travels alongside for expansion
  always_ff @(posedge clk)
  begin
    s0_state <= plaintext ^ key;
    s0_key   <= key;
  end

  assign stage_valid[0] = s0_valid;
  assign stage_state[0] = s0_state;
  assign stage_key[0]   = s0_key;

  for (genvar i = 1; i <= aes_pkg::num_rounds; i++)
  begin : g_stage
    aes_key_stage #(
      .round_const (aes_pkg::rcon(i))
    ) u_key_stage (
      .clk       (clk),
      .key_prev  (stage_key[i-1]),
      .round_key (round_key[i]),
      .key_next  (stage_key[i])
    );

    aes_round #(
      .is_final (i == aes_pkg::num_rounds)
    ) u_round (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid_in  (stage_valid[i-1]),
      .state_in  (stage_state[i-1]),
      .round_key (round_key[i]),
      .valid_out (stage_valid[i]),
      .state_out (stage_state[i])
    );
  end

  assign ciphertext = stage_state[aes_pkg::num_rounds];
  assign out_valid  = stage_valid[aes_pkg::num_rounds];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      since_reset <= '0;
    end
    else if (since_reset != aes_pkg::pipe_latency)
    begin
      since_reset <= since_reset + 1'b1;
    end
  end

  // every accepted block leaves exactly pipe_latency cycles later
  a_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    (since_reset == aes_pkg::pipe_latency)
      |-> (out_valid == $past(in_valid, aes_pkg::pipe_latency))
  );

endmodule

/* aes_round.sv */
`timescale 1ns/1ps

module aes_round #(
  parameter bit is_final = 1'b0
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            valid_in,
  input  aes_pkg::block_t state_in,
  input  aes_pkg::block_t round_key,
  output logic            valid_out,
  output aes_pkg::block_t state_out
);

  localparam int num_bytes = aes_pkg::block_w / 8;
  localparam int word_bytes = aes_pkg::word_w / 8;
  localparam int num_cols = num_bytes / word_bytes;

  aes_pkg::byte_t sub_bytes [0:num_bytes-1];
  aes_pkg::block_t shifted;
  aes_pkg::block_t mixed;

  // one column times the fixed MixColumns matrix
  function automatic aes_pkg::word_t mix_column(input aes_pkg::word_t a);
    aes_pkg::word_t b;
    aes_pkg::byte_t t;
    t = a[0] ^ a[1] ^ a[2] ^ a[3];
    for (int r = 0; r < word_bytes; r++)
    begin
      b[r] = a[r] ^ t ^ aes_pkg::xtime(a[r] ^ a[(r + 1) % word_bytes]);
    end
    return b;
  endfunction

  // SubBytes
  for (genvar k = 0; k < num_bytes; k++)
  begin : g_sub_bytes
    aes_sbox u_sbox (
      .in_byte  (state_in[k]),
      .out_byte (sub_bytes[k])
    );
  end

  // ShiftRows rotates each row left by its row number
  // byte k sits in row k%4
  always_comb
  begin
    for (int k = 0; k < num_bytes; k++)
    begin
      shifted[k] = sub_bytes[(k + word_bytes * (k % word_bytes)) % num_bytes];
    end
  end

  if (is_final)
  begin : g_no_mix
    // last round skips MixColumns
    assign mixed = shifted;
  end
  else
  begin : g_mix
    always_comb
    begin
      for (int c = 0; c < num_cols; c++)
      begin
        mixed[c*word_bytes +: word_bytes] = mix_column(shifted[c*word_bytes +: word_bytes]);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_out <= 1'b0;
    end
    else
    begin
      valid_out <= valid_in;
    end
  end

  // AddRoundKey into the stage register
  always_ff @(posedge clk)
  begin
    state_out <= mixed ^ round_key;
  end

  // valid chain must be clean once reset has been applied
  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(valid_out)
  );

endmodule

/* aes_key_stage.sv */
`timescale 1ns/1ps

module aes_key_stage #(
  parameter aes_pkg::byte_t round_const = 8'h01
) (
  input  logic            clk,
  input  aes_pkg::block_t key_prev,
  output aes_pkg::block_t round_key,
  output aes_pkg::block_t key_next
);

  localparam int word_bytes = aes_pkg::word_w / 8;
  localparam int num_words = aes_pkg::block_w / aes_pkg::word_w;

  // first byte of the last key word
  localparam int last_base = (num_words - 1) * word_bytes;

  aes_pkg::byte_t sub_word [0:word_bytes-1];
  aes_pkg::word_t temp;
  aes_pkg::word_t new_word [0:num_words-1];

  // SubWord(RotWord(w3)) with the rotation done by picking the input byte
  for (genvar j = 0; j < word_bytes; j++)
  begin : g_sub_word
    aes_sbox u_sbox (
      .in_byte  (key_prev[last_base + (j + 1) % word_bytes]),
      .out_byte (sub_word[j])
    );
  end

  always_comb
  begin
    temp = {sub_word[0] ^ round_const, sub_word[1], sub_word[2], sub_word[3]};
    new_word[0] = key_prev[0 +: word_bytes] ^ temp;
    // each later word folds in the one just produced
    for (int j = 1; j < num_words; j++)
    begin
      new_word[j] = key_prev[j*word_bytes +: word_bytes] ^ new_word[j-1];
    end
  end

  // used by this stage's round in the same cycle
  assign round_key = {new_word[0], new_word[1], new_word[2], new_word[3]};

  // handed on one cycle later in step with the round's state register
  always_ff @(posedge clk)
  begin
    key_next <= round_key;
  end

endmodule

/* aes_sbox.sv */
`timescale 1ns/1ps

module aes_sbox (
  input  aes_pkg::byte_t in_byte,
  output aes_pkg::byte_t out_byte
);

  // constant term of the affine map
  localparam aes_pkg::byte_t affine_c = 8'h63;

  aes_pkg::byte_t pow;
  aes_pkg::byte_t inv;

  // shift-and-add product in GF(2^8)
  function automatic aes_pkg::byte_t gf_mul(
    input aes_pkg::byte_t a,
    input aes_pkg::byte_t b
  );
    aes_pkg::byte_t acc;
    aes_pkg::byte_t sh;
    acc = '0;
    sh = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        acc = acc ^ sh;
      end
      sh = aes_pkg::xtime(sh);
    end
    return acc;
  endfunction

  // inverse as a^254 = a^2 * a^4 * ... * a^128
  // zero stays zero as AES requires
  always_comb
  begin
    pow = in_byte;
    inv = 8'h01;
    for (int k = 1; k < 8; k++)
    begin
      pow = gf_mul(pow, pow);
      inv = gf_mul(inv, pow);
    end
  end

  // affine map xors the inverse with its rotations by 1 to 4
  assign out_byte = inv
                  ^ {inv[6:0], inv[7]}
                  ^ {inv[5:0], inv[7:6]}
                  ^ {inv[4:0], inv[7:5]}
                  ^ {inv[3:0], inv[7:4]}
                  ^ affine_c;

endmodule

/* aes_pkg.sv */
package aes_pkg;

  // block and column widths
  localparam int block_w = 128;
  localparam int word_w = 32;

  // round count and the latency that adds the initial key addition
  localparam int num_rounds = 10;
  localparam int pipe_latency = num_rounds + 1;

  typedef logic [7:0] byte_t;

  // byte 0 sits in the most significant bits as in FIPS-197
  typedef byte_t [0:word_w/8-1] word_t;
  typedef byte_t [0:block_w/8-1] block_t;

  // multiply by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
  function automatic byte_t xtime(input byte_t b);
    byte_t r;
    r = {b[6:0], 1'b0};
    if (b[7])
    begin
      r = r ^ 8'h1b;
    end
    return r;
  endfunction

  // round constant for rounds 1 to 10
  // repeated doubling gives 01 02 04 08 10 20 40 80 1b 36
  function automatic byte_t rcon(input int unsigned idx);
    byte_t r;
    r = 8'h01;
    for (int unsigned i = 1; i < idx; i++)
    begin
      r = xtime(r);
    end
    return r;
  endfunction

endpackage
